// File: common/bus_pkg.sv
// host register bus types, shared by the controller and its testbench.
// one access per cycle. writes land on the clock edge where wr is high,
// reads are combinational from addr.
package bus_pkg;

	// word addressed register map.
	typedef enum logic [3:0] {
		ADDR_LO = 4'd0,
		ADDR_HI = 4'd1,
		CMD     = 4'd2,
		DATA    = 4'd3,
		STATUS  = 4'd4
	} reg_addr_e;

	typedef struct packed {
		reg_addr_e   addr;
		logic [15:0] wdata;
		logic        wr;
	} bus_req_t;

endpackage

// File: common/flash_pkg.sv
// flash side types used between the register block and the SPI sequencer.
// opcodes follow the usual serial NOR command set.
package flash_pkg;

	// fixed by the flash device and the 16-bit host registers.
	localparam int FLASH_ADDR_BITS = 23;
	localparam int DATA_BITS = 16;

	typedef enum logic [7:0] {
		OP_READ = 8'h03,
		OP_WAKE = 8'hAB
	} opcode_e;

	typedef enum logic [2:0] {
		IDLE,
		SEND_OP,
		SEND_ADDR,
		GET_DATA,
		DONE
	} seq_state_e;

	typedef struct packed {
		logic                       go;
		opcode_e                    op;
		logic                       with_addr;
		logic [FLASH_ADDR_BITS-1:0] addr;
	} xfer_req_t;

endpackage

// File: rtl/flash_regs.sv
// host register block of the flash reader.
// holds the byte address, done status and last read word, and turns a CMD
// write into a one-cycle transfer request when the sequencer is idle.
`timescale 1ns/10ps

module flash_regs (
	input  logic                            CLK,
	input  logic                            RSTb,
	input  bus_pkg::bus_req_t               bus,
	output logic [15:0]                     rdata,
	input  logic                            busy,
	input  logic                            result_valid,
	input  logic [flash_pkg::DATA_BITS-1:0] result,
	output flash_pkg::xfer_req_t            req
);
	localparam int HI_BITS = flash_pkg::FLASH_ADDR_BITS - 16;

	logic [15:0]                     addr_lo;
	logic [HI_BITS-1:0]              addr_hi;
	logic [flash_pkg::DATA_BITS-1:0] data_r;
	logic                            done_r;
	logic                            go_r;
	logic                            is_read;
	logic                            issue;

	// a second command before the first one is taken is dropped.
	assign issue = bus.wr && (bus.addr == bus_pkg::CMD) && !busy && !go_r &&
		(bus.wdata[0] || bus.wdata[1]);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			addr_lo <= '0;
			addr_hi <= '0;
			data_r <= '0;
			done_r <= 1'b0;
			go_r <= 1'b0;
			is_read <= 1'b0;
		end else begin
			go_r <= issue;
			if (bus.wr && (bus.addr == bus_pkg::ADDR_LO))
				addr_lo <= bus.wdata;
			if (bus.wr && (bus.addr == bus_pkg::ADDR_HI))
				addr_hi <= bus.wdata[HI_BITS-1:0];
			if (issue) begin
				done_r <= 1'b0;
				is_read <= bus.wdata[0];
			end else if (result_valid) begin
				done_r <= 1'b1;
				// wake carries no data.
				if (is_read)
					data_r <= result;
			end
		end
	end

	always_comb begin
		req.go = go_r;
		req.with_addr = is_read;
		req.addr = {addr_hi, addr_lo};
		if (is_read)
			req.op = flash_pkg::OP_READ;
		else
			req.op = flash_pkg::OP_WAKE;
	end

	// first flash byte sits in the upper half of data_r.
	always_comb begin
		case (bus.addr)
			bus_pkg::ADDR_LO: rdata = addr_lo;
			bus_pkg::ADDR_HI: rdata = {{(16 - HI_BITS){1'b0}}, addr_hi};
			bus_pkg::DATA:    rdata = {data_r[7:0], data_r[15:8]};
			bus_pkg::STATUS:  rdata = {15'd0, done_r};
			default:          rdata = 16'd0;
		endcase
	end

endmodule

// File: spi_master/spi_sequencer.sv
// phase sequencer for the SPI flash reader.
// walks opcode, address and data phases, loading the bit shifter for each one
// and handing the captured word back to the register block.
`timescale 1ns/10ps

module spi_sequencer (
	input  logic                            CLK,
	input  logic                            RSTb,
	input  flash_pkg::xfer_req_t            req,
	input  logic                            bit_last,
	input  logic [flash_pkg::DATA_BITS-1:0] rx_word,
	output logic                            load,
	output logic [23:0]                     tx_word,
	output logic [4:0]                      bit_count,
	output logic                            sample_en,
	output logic                            cs_active,
	output logic                            busy,
	output logic                            result_valid,
	output logic [flash_pkg::DATA_BITS-1:0] result
);
	localparam int ADDR_PAD = 24 - flash_pkg::FLASH_ADDR_BITS;

	flash_pkg::seq_state_e                 state;
	flash_pkg::seq_state_e                 state_next;
	logic                                  with_addr_r;
	logic [flash_pkg::FLASH_ADDR_BITS-1:0] addr_r;
	logic                                  start;

	assign start = (state == flash_pkg::IDLE) && req.go;

	// next phase is loaded in the bit_last cycle so SCK runs on without a gap.
	always_comb begin
		state_next = state;
		load = 1'b0;
		tx_word = 24'd0;
		bit_count = 5'd0;
		case (state)
			flash_pkg::IDLE:
				if (req.go) begin
					load = 1'b1;
					tx_word = {req.op, 16'h0000};
					bit_count = 5'd8;
					state_next = flash_pkg::SEND_OP;
				end
			flash_pkg::SEND_OP:
				if (bit_last) begin
					if (with_addr_r) begin
						load = 1'b1;
						tx_word = {{ADDR_PAD{1'b0}}, addr_r};
						bit_count = 5'd24;
						state_next = flash_pkg::SEND_ADDR;
					end else begin
						state_next = flash_pkg::DONE;
					end
				end
			flash_pkg::SEND_ADDR:
				if (bit_last) begin
					load = 1'b1;
					bit_count = 5'(flash_pkg::DATA_BITS);
					state_next = flash_pkg::GET_DATA;
				end
			flash_pkg::GET_DATA:
				if (bit_last)
					state_next = flash_pkg::DONE;
			flash_pkg::DONE:
				state_next = flash_pkg::IDLE;
			default:
				state_next = flash_pkg::IDLE;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= flash_pkg::IDLE;
			cs_active <= 1'b0;
			with_addr_r <= 1'b0;
		end else begin
			state <= state_next;
			cs_active <= (state_next == flash_pkg::SEND_OP) ||
				(state_next == flash_pkg::SEND_ADDR) ||
				(state_next == flash_pkg::GET_DATA);
			if (start)
				with_addr_r <= req.with_addr;
		end
	end

	// host may rewrite the address registers while a read runs.
	always_ff @(posedge CLK) begin
		if (start)
			addr_r <= req.addr;
	end

	assign sample_en = (state == flash_pkg::GET_DATA);
	assign busy = (state != flash_pkg::IDLE);
	assign result_valid = (state == flash_pkg::DONE);
	assign result = with_addr_r ? rx_word : '0;

endmodule

// File: spi_master/spi_shifter.sv
// SPI mode 0 bit engine.
// each bit lasts 2**TICK_BITS clocks with SCK high in the second half.
// MOSI shifts out MSB first, MISO is sampled as SCK rises.
`timescale 1ns/10ps

module spi_shifter #(
	parameter int TICK_BITS = 3
) (
	input  logic                            CLK,
	input  logic                            RSTb,
	input  logic                            load,
	input  logic [23:0]                     tx_word,
	input  logic [4:0]                      bit_count,
	input  logic                            sample_en,
	input  logic                            cs_active,
	output logic                            bit_last,
	output logic [flash_pkg::DATA_BITS-1:0] rx_word,
	output logic                            MOSI,
	input  logic                            MISO,
	output logic                            SCK,
	output logic                            CSb
);
	// last tick before SCK goes high.
	localparam logic [TICK_BITS-1:0] HALF_M1 = TICK_BITS'((1 << (TICK_BITS - 1)) - 1);

	logic [TICK_BITS-1:0] tick;
	logic [4:0]           bits_left;
	logic [23:0]          shift_r;
	logic                 active;
	logic                 bit_end;

	assign bit_end = active && (&tick);
	assign bit_last = bit_end && (bits_left == 5'd1);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			tick <= '0;
			bits_left <= 5'd0;
			active <= 1'b0;
		end else if (load) begin
			tick <= '0;
			bits_left <= bit_count;
			active <= 1'b1;
		end else if (active) begin
			tick <= tick + 1'b1;
			if (bit_end) begin
				bits_left <= bits_left - 1'b1;
				if (bits_left == 5'd1)
					active <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (load)
			shift_r <= tx_word;
		else if (bit_end)
			shift_r <= {shift_r[22:0], 1'b0};
		if (active && sample_en && (tick == HALF_M1))
			rx_word <= {rx_word[flash_pkg::DATA_BITS-2:0], MISO};
	end

	// tick wraps to zero at every bit end, so SCK is low at CSb edges.
	assign SCK = tick[TICK_BITS-1];
	assign MOSI = active ? shift_r[23] : 1'b0;
	assign CSb = ~cs_active;

endmodule

// File: rtl/flash_ctrl_top.sv
// top level of the SPI flash reader.
// host register bus in, SPI pins out. TICK_BITS sets the SCK period.
`timescale 1ns/10ps

module flash_ctrl_top #(
	parameter int TICK_BITS = 3
) (
	input  logic              CLK,
	input  logic              RSTb,
	input  bus_pkg::bus_req_t bus,
	output logic [15:0]       rdata,
	output logic              MOSI,
	input  logic              MISO,
	output logic              SCK,
	output logic              CSb
);
	flash_pkg::xfer_req_t            req;
	logic                            busy;
	logic                            result_valid;
	logic [flash_pkg::DATA_BITS-1:0] result;
	logic [flash_pkg::DATA_BITS-1:0] rx_word;
	logic                            load;
	logic [23:0]                     tx_word;
	logic [4:0]                      bit_count;
	logic                            sample_en;
	logic                            cs_active;
	logic                            bit_last;

	flash_regs u_regs (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.bus          (bus),
		.rdata        (rdata),
		.busy         (busy),
		.result_valid (result_valid),
		.result       (result),
		.req          (req)
	);

	spi_sequencer u_seq (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.req          (req),
		.bit_last     (bit_last),
		.rx_word      (rx_word),
		.load         (load),
		.tx_word      (tx_word),
		.bit_count    (bit_count),
		.sample_en    (sample_en),
		.cs_active    (cs_active),
		.busy         (busy),
		.result_valid (result_valid),
		.result       (result)
	);

	spi_shifter #(
		.TICK_BITS (TICK_BITS)
	) u_shift (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.load      (load),
		.tx_word   (tx_word),
		.bit_count (bit_count),
		.sample_en (sample_en),
		.cs_active (cs_active),
		.bit_last  (bit_last),
		.rx_word   (rx_word),
		.MOSI      (MOSI),
		.MISO      (MISO),
		.SCK       (SCK),
		.CSb       (CSb)
	);

endmodule

// File: test/flash_model.sv
// behavioral SPI flash for the reader testbench.
// answers 03h reads with contents computed from the address and counts ABh wakes.
`timescale 1ns/10ps

module flash_model (
	input  logic SCK,
	input  logic CSb,
	input  logic MOSI,
	output logic MISO
);
	int          bit_cnt;
	int          cmd_count;
	int          wake_count;
	logic [7:0]  opcode;
	logic [31:0] in_sr;
	logic [15:0] out_sr;

	// content rule of the array.
	function automatic logic [7:0] content(input logic [23:0] a);
		return a[7:0] ^ a[15:8] ^ 8'hA5;
	endfunction

	initial begin
		bit_cnt = 0;
		cmd_count = 0;
		wake_count = 0;
		opcode = 8'h00;
		in_sr = '0;
		out_sr = '0;
		MISO = 1'b0;
	end

	always @(negedge CSb)
		bit_cnt = 0;

	// mode 0, MOSI is taken on the rising SCK edge.
	always @(posedge SCK) begin
		if (!CSb) begin
			in_sr = {in_sr[30:0], MOSI};
			bit_cnt = bit_cnt + 1;
			if (bit_cnt == 8) begin
				opcode = in_sr[7:0];
				cmd_count = cmd_count + 1;
				if (opcode == 8'hAB)
					wake_count = wake_count + 1;
			end
			// address auto increments into the second byte.
			if (bit_cnt == 32 && opcode == 8'h03)
				out_sr = {content(in_sr[23:0]), content(in_sr[23:0] + 24'd1)};
		end
	end

	always @(negedge SCK) begin
		if (!CSb && opcode == 8'h03 && bit_cnt >= 32) begin
			MISO = out_sr[15];
			out_sr = {out_sr[14:0], 1'b0};
		end
	end

endmodule

// File: test/flash_ctrl_props.sv
// SPI pin protocol assertions, bound into spi_shifter by the testbench.
`timescale 1ns/10ps

module flash_ctrl_props (
	input logic CLK,
	input logic RSTb,
	input logic CSb,
	input logic SCK,
	input logic MOSI,
	input logic active
);
	// mode 0 keeps SCK idle low around chip select edges.
	a_sck_low_at_cs: assert property (@(posedge CLK) disable iff (!RSTb)
		$changed(CSb) |-> !SCK)
		else $error("SCK high while CSb changed");

	a_mosi_idle: assert property (@(posedge CLK) disable iff (!RSTb) CSb |-> !MOSI)
		else $error("MOSI high while CSb is high");

	// the shifter only runs inside a transfer.
	a_cs_held: assert property (@(posedge CLK) disable iff (!RSTb) active |-> !CSb)
		else $error("CSb high while bits are still shifting");

endmodule

// File: test/flash_ctrl_tb.sv
// testbench for the SPI flash reader.
// replays test/flash_stimulus.txt against flash_ctrl_top with a flash model on the pins,
// checking the DATA word, the done bit and the commands the model sees.
`timescale 1ns/10ps

module flash_ctrl_tb;
	logic              CLK;
	logic              RSTb;
	bus_pkg::bus_req_t bus;
	logic [15:0]       rdata;
	logic              MOSI;
	logic              MISO;
	logic              SCK;
	logic              CSb;
	int                op_kind[$];
	logic [23:0]       op_addr[$];
	logic [15:0]       op_expect[$];
	int                cycle_count = 0;
	int                cycle_limit = 200;

	flash_ctrl_top #(.TICK_BITS(3)) UUT (
		.CLK(CLK), .RSTb(RSTb), .bus(bus), .rdata(rdata),
		.MOSI(MOSI), .MISO(MISO), .SCK(SCK), .CSb(CSb)
	);

	flash_model u_flash (.SCK(SCK), .CSb(CSb), .MOSI(MOSI), .MISO(MISO));

	bind spi_shifter flash_ctrl_props u_props (
		.CLK(CLK), .RSTb(RSTb), .CSb(CSb), .SCK(SCK), .MOSI(MOSI), .active(active)
	);

	initial CLK = 1'b0;
	always #50 CLK = ~CLK;

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, the DUT never reported done", cycle_count);
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "stimulus problem");
	endtask

	task automatic check_word(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h",
				$time, name, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "wrong value on %s", name);
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s is %b, expected %b",
				$time, name, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "wrong value on %s", name);
		end
	endtask

	task automatic check_count(input string name, input int actual, input int expected);
		if (actual != expected) begin
			$display("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
				$time, name, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "wrong value on %s", name);
		end
	endtask

	task automatic load_stimulus();
		int          fd;
		int          c;
		int          n;
		logic [23:0] a;
		logic [15:0] e;
		fd = $fopen("test/flash_stimulus.txt", "r");
		if (fd == 0)
			stop_on_error("cannot open test/flash_stimulus.txt from the project root");
		c = $fgetc(fd);
		while (c != -1) begin
			if (c == "#") begin
				while (c != -1 && c != "\n")
					c = $fgetc(fd);
			end else if (c >= "0" && c <= "9") begin
				n = $fscanf(fd, "%h %h\n", a, e);
				if (n != 2)
					stop_on_error("malformed line in the stimulus file");
				op_kind.push_back(c - "0");
				op_addr.push_back(a);
				op_expect.push_back(e);
			end
			c = $fgetc(fd);
		end
		$fclose(fd);
		cycle_limit = op_kind.size() * 60 * 8 + 200;
	endtask

	// drive on the rising edge, the DUT takes the write on the next one.
	task automatic write_reg(input bus_pkg::reg_addr_e a, input logic [15:0] d);
		@(posedge CLK);
		bus <= '{addr: a, wdata: d, wr: 1'b1};
		@(posedge CLK);
		bus <= '{addr: a, wdata: 16'd0, wr: 1'b0};
	endtask

	task automatic read_reg(input bus_pkg::reg_addr_e a, output logic [15:0] d);
		@(posedge CLK);
		bus <= '{addr: a, wdata: 16'd0, wr: 1'b0};
		@(negedge CLK);
		d = rdata;
	endtask

	task automatic write_address(input logic [23:0] a);
		write_reg(bus_pkg::ADDR_LO, a[15:0]);
		write_reg(bus_pkg::ADDR_HI, {8'd0, a[23:16]});
	endtask

	task automatic wait_for_done();
		logic [15:0] v;
		v = 16'd0;
		while (!v[0])
			read_reg(bus_pkg::STATUS, v);
		check_flag("CSb", CSb, 1'b1);
	endtask

	task automatic read_flash(input logic [23:0] a, input logic extra_cmd);
		int          cmds_before;
		logic [15:0] v;
		cmds_before = u_flash.cmd_count;
		write_address(a);
		write_reg(bus_pkg::CMD, 16'h0001);
		read_reg(bus_pkg::STATUS, v);
		check_flag("done", v[0], 1'b0);
		check_flag("CSb", CSb, 1'b0);
		// a wake request that lands in the opcode phase and has to be dropped.
		if (extra_cmd) begin
			write_reg(bus_pkg::CMD, 16'h0002);
			read_reg(bus_pkg::STATUS, v);
			check_flag("done", v[0], 1'b0);
		end
		wait_for_done();
		check_count("flash command count", u_flash.cmd_count, cmds_before + 1);
	endtask

	task automatic wake_flash();
		int          cmds_before;
		int          wakes_before;
		logic [15:0] v;
		cmds_before = u_flash.cmd_count;
		wakes_before = u_flash.wake_count;
		write_reg(bus_pkg::CMD, 16'h0002);
		read_reg(bus_pkg::STATUS, v);
		check_flag("done", v[0], 1'b0);
		check_flag("CSb", CSb, 1'b0);
		wait_for_done();
		check_count("flash wake count", u_flash.wake_count, wakes_before + 1);
		check_count("flash command count", u_flash.cmd_count, cmds_before + 1);
	endtask

	task automatic set_address_only(input logic [23:0] a);
		int cmds_before;
		cmds_before = u_flash.cmd_count;
		write_address(a);
		repeat (100) begin
			@(negedge CLK);
			check_flag("CSb", CSb, 1'b1);
		end
		check_count("flash command count", u_flash.cmd_count, cmds_before);
	endtask

	initial begin
		logic [15:0] v;
		int          gap;
		RSTb = 1'b0;
		bus = '{addr: bus_pkg::ADDR_LO, wdata: 16'd0, wr: 1'b0};
		void'($urandom(44));
		load_stimulus();
		repeat (3) @(posedge CLK);
		RSTb <= 1'b1;
		read_reg(bus_pkg::STATUS, v);
		check_word("STATUS", v, 16'd0);
		read_reg(bus_pkg::DATA, v);
		check_word("DATA", v, 16'd0);
		check_flag("CSb", CSb, 1'b1);
		check_flag("SCK", SCK, 1'b0);
		foreach (op_kind[i]) begin
			gap = 1 + int'($urandom % 12);
			repeat (gap) @(posedge CLK);
			case (op_kind[i])
				0: read_flash(op_addr[i], 1'b0);
				1: wake_flash();
				2: read_flash(op_addr[i], 1'b1);
				3: set_address_only(op_addr[i]);
				default: stop_on_error("unknown operation kind in the stimulus file");
			endcase
			read_reg(bus_pkg::DATA, v);
			check_word("DATA", v, op_expect[i]);
		end
		$display("TEST OK");
		$finish;
	end

endmodule

// File: test/flash_stimulus.txt
# columns are kind, byte address and the DATA word expected afterwards, all hex
# kind 0 read, 1 wake, 2 read with a second CMD write while busy, 3 address write only
0 000000 A4A5
0 000123 8087
0 7FFFFE A5A4
0 00FFFF A5A5
1 000000 A5A5
0 4A3C5D C7C4
3 123456 C7C4
2 002A80 0E0F
1 000000 0E0F
0 3F00FF A45A

// File: spi_flash_sub.f
common/bus_pkg.sv
common/flash_pkg.sv
rtl/flash_regs.sv
spi_master/spi_sequencer.sv
spi_master/spi_shifter.sv
rtl/flash_ctrl_top.sv
test/flash_model.sv
test/flash_ctrl_props.sv
test/flash_ctrl_tb.sv

// File: Makefile
# Verilator build and run of the SPI flash reader testbench.
VERILATOR ?= verilator
TOP       ?= flash_ctrl_tb
FILELIST  ?= spi_flash_sub.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal --top-module $(TOP)

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
